// File: sources.f
verilog/pbiBusPkg.sv
verilog/cardPkg.sv
verilog/cardRam.sv
verilog/spiShifter.sv
verilog/localBusArbiter.sv
verilog/dmaEngine.sv
verilog/pbiRegDecode.sv
verilog/pbiCard.sv
tests/pbiCardTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       ?= pbiCardTb
FILELIST  ?= sources.f
OBJDIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# The status of grep decides pass or fail
run: build
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "Test OK"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// File: tests/pbiCardTb.sv
module pbiCardTb;

    localparam int clkPeriod   = 4;
    localparam int numRandom   = 150;
    localparam int numDmaRuns  = 10;
    // RAM fill, random phases, then DMA setup, polling and readback
    localparam int numAccesses = 2100 + 3 * numRandom + numDmaRuns * 110;
    localparam logic [7:0] devOneHot = 8'h08;  // devId 3

    logic               clk1 = 1'b0;
    logic               rstN;
    logic [2:0]         devId;
    pbiBusPkg::hostReqT hostReq;
    logic               hostReqValid;
    logic               hostAck;
    logic [7:0]         hostRdata;
    logic               spiLoop;  // spiDo wired back to spiDi
    logic               spiClk;
    logic               spiCs;

    // Reference model
    logic [7:0]  modelMem [2048];
    logic        modelSel;
    logic [3:0]  modelBank;
    logic [10:0] modelDmaAddr;
    logic [15:0] modelDmaCount;
    logic        modelBusy;
    logic        modelCs;
    logic [7:0]  modelSpi;  // Last byte that went round the loop

    integer seed = 39;
    int     dataErrors = 0;
    int     statusErrors = 0;
    int     pinErrors = 0;
    int     spiEdges = 0;  // Rising spiClk edges seen so far

    pbiCard DUT (
        .clk1, .rstN, .devId, .hostReq, .hostReqValid, .hostAck, .hostRdata,
        .spiDi(spiLoop), .spiDo(spiLoop), .spiClk, .spiCs
    );

    always #(clkPeriod / 2) clk1 = ~clk1;

    always @(posedge spiClk) spiEdges++;

    initial begin
        #(numAccesses * 200 * clkPeriod);
        $display("Watchdog expired before the tests finished");
        $display("Test FAILED");
        $finish;
    end

    task automatic checkData(input logic [7:0] got, input logic [7:0] exp,
                             input logic [15:0] addr);
        if (got !== exp) begin
            dataErrors++;
            $display("FAILED at %0t: hostRdata from %h is %h, expected %h",
                     $time, addr, got, exp);
        end
    endtask

    task automatic checkStatus(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            statusErrors++;
            $display("FAILED at %0t: status is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic checkPin(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            pinErrors++;
            $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    // 8 rising spiClk edges per byte shifted
    task automatic checkEdges(input int got, input int exp);
        if (got != exp) begin
            pinErrors++;
            $display("FAILED at %0t: spiClk rose %0d times, expected %0d",
                     $time, got, exp);
        end
    endtask

    // One four-phase host access, sampled 1 unit after each edge
    task automatic hostCycle(input logic [15:0] addr, input logic [7:0] wdata,
                             input logic write, output logic [7:0] rdata);
        @(posedge clk1);
        #1;
        hostReq.addr  = addr;
        hostReq.wdata = wdata;
        hostReq.write = write;
        hostReqValid  = 1'b1;
        do begin
            @(posedge clk1);
            #1;
        end while (!hostAck);
        rdata        = hostRdata;
        hostReqValid = 1'b0;
        do begin
            @(posedge clk1);
            #1;
        end while (hostAck);
    endtask

    // Expected read data for one access, then its effect on the model
    task automatic modelAccess(input logic [15:0] addr, input logic [7:0] wdata,
                               input logic write, output logic [7:0] exp);
        logic [10:0] ramIdx;
        logic        dmaOpen;
        ramIdx  = {modelBank, addr[6:0]};
        dmaOpen = write && !modelBusy;
        exp     = 8'hFF;
        if (addr == pbiBusPkg::selectAddr) begin
            if (write) modelSel = wdata == devOneHot;
        end else if (!modelSel) begin
            exp = 8'hFF;  // Deselected card floats
        end else if (addr >= 16'hD100 && addr <= 16'hD17F) begin
            exp = modelMem[ramIdx];
            if (write) modelMem[ramIdx] = wdata;
        end else if (addr[15:4] == 12'hD1E) begin
            exp = {4'h0, modelBank};
            if (write) modelBank = addr[3:0];
        end else begin
            case (addr)
                pbiBusPkg::dmaAddrLo: begin
                    exp = modelDmaAddr[7:0];
                    if (dmaOpen) modelDmaAddr[7:0] = wdata;
                end
                pbiBusPkg::dmaAddrHi: begin
                    exp = {5'h0, modelDmaAddr[10:8]};
                    if (dmaOpen) modelDmaAddr[10:8] = wdata[2:0];
                end
                pbiBusPkg::dmaCountLo: begin
                    exp = modelDmaCount[7:0];
                    if (dmaOpen) modelDmaCount[7:0] = wdata;
                end
                pbiBusPkg::dmaCountHi: begin
                    exp = modelDmaCount[15:8];
                    if (dmaOpen) modelDmaCount[15:8] = wdata;
                end
                pbiBusPkg::dmaStart: if (dmaOpen) modelBusy = modelDmaCount != 16'd0;
                pbiBusPkg::statusAddr: exp = {6'h0, modelCs, modelBusy};
                pbiBusPkg::spiSelAddr: begin
                    exp = {7'h0, modelCs};
                    if (write) modelCs = wdata[0];
                end
                pbiBusPkg::spiDataAddr: begin
                    if (write) modelSpi = wdata;
                    exp = modelSpi;  // Loopback returns what was sent
                end
                default: exp = 8'hFF;
            endcase
        end
    endtask

    task automatic doAccess(input logic [15:0] addr, input logic [7:0] wdata,
                            input logic write);
        logic [7:0] exp;
        logic [7:0] got;
        modelAccess(addr, wdata, write, exp);
        hostCycle(addr, wdata, write, got);
        if (!write) checkData(got, exp, addr);
    endtask

    task automatic randomPageAccesses();
        logic [31:0] r;
        logic [15:0] addr;
        for (int i = 0; i < 20; i++) begin
            r    = $random(seed);
            addr = {8'hD1, r[7:0]};
            if (addr == pbiBusPkg::selectAddr) addr = pbiBusPkg::spiDataAddr;
            doAccess(addr, r[15:8], r[16]);
        end
    endtask

    task automatic fillRam();
        logic [31:0] r;
        for (int b = 0; b < 16; b++) begin
            doAccess(pbiBusPkg::ramBankAddr + 16'(b), 8'h00, 1'b1);
            for (int o = 0; o < 128; o++) begin
                r = $random(seed);
                doAccess(pbiBusPkg::ramWinBase + 16'(o), r[7:0], 1'b1);
            end
        end
    endtask

    task automatic windowAccesses();
        logic [31:0] r;
        for (int i = 0; i < numRandom; i++) begin
            r = $random(seed);
            case (r[1:0])
                2'd0: doAccess(pbiBusPkg::ramBankAddr + 16'(r[11:8]), 8'h00, 1'b1);
                2'd1: doAccess(pbiBusPkg::ramWinBase + 16'(r[14:8]), r[23:16], 1'b1);
                default: doAccess(pbiBusPkg::ramWinBase + 16'(r[14:8]), 8'h00, 1'b0);
            endcase
        end
    endtask

    task automatic spiAccesses();
        logic [31:0] r;
        logic [7:0]  st;
        int          edges;
        for (int i = 0; i < 10; i++) begin
            r = $random(seed);
            doAccess(pbiBusPkg::spiSelAddr, r[7:0], 1'b1);
            checkPin("spiCs", spiCs, modelCs);
            hostCycle(pbiBusPkg::statusAddr, 8'h00, 1'b0, st);
            checkStatus(st, {6'h0, modelCs, 1'b0});
            edges = spiEdges;
            doAccess(pbiBusPkg::spiDataAddr, r[15:8], 1'b1);
            doAccess(pbiBusPkg::spiDataAddr, 8'h00, 1'b0);
            checkEdges(spiEdges - edges, 16);  // Two bytes
            checkPin("spiClk", spiClk, 1'b0);  // Idles low between bytes
        end
    endtask

    // Traffic keeps the host in banks 8..15, away from the DMA range
    task automatic runDma(input logic dir, input logic traffic);
        logic [31:0] r;
        logic [10:0] start;
        logic [10:0] idx;
        logic [15:0] count;
        logic [7:0]  st;
        int          edges;
        r     = $random(seed);
        start = traffic ? {2'b00, r[8:0]} : r[10:0];
        count = 16'(r[14:12]) + 16'd1;
        doAccess(pbiBusPkg::dmaAddrLo, start[7:0], 1'b1);
        doAccess(pbiBusPkg::dmaAddrHi, {5'h0, start[10:8]}, 1'b1);
        doAccess(pbiBusPkg::dmaCountLo, count[7:0], 1'b1);
        doAccess(pbiBusPkg::dmaCountHi, count[15:8], 1'b1);
        edges = spiEdges;
        doAccess(pbiBusPkg::dmaStart, {7'h0, dir}, 1'b1);
        if (traffic) begin
            doAccess(pbiBusPkg::dmaAddrLo, ~start[7:0], 1'b1);  // Busy, must be dropped
            doAccess(pbiBusPkg::dmaStart, {7'h0, ~dir}, 1'b1);
            for (int i = 0; i < 12; i++) begin
                r = $random(seed);
                if (i % 4 == 0) begin
                    doAccess({12'hD1E, 1'b1, r[2:0]}, 8'h00, 1'b1);
                end else begin
                    doAccess(pbiBusPkg::ramWinBase + 16'(r[14:8]), r[23:16], r[4]);
                end
            end
        end
        do begin
            hostCycle(pbiBusPkg::statusAddr, 8'h00, 1'b0, st);
        end while (st[0] === 1'b1);
        checkEdges(spiEdges - edges, 8 * int'(count));  // One SPI byte per DMA byte
        // Transfer is over, apply it byte by byte
        for (int i = 0; i < int'(count); i++) begin
            idx = start + 11'(i);
            if (dir) modelMem[idx] = cardPkg::spiFill;
            else modelSpi = modelMem[idx];
        end
        if (dir) modelSpi = cardPkg::spiFill;
        modelBusy = 1'b0;
        checkStatus(st, {6'h0, modelCs, 1'b0});
        if (dir) begin
            for (int i = -2; i < int'(count) + 2; i++) begin
                idx = start + 11'(i);
                doAccess(pbiBusPkg::ramBankAddr + 16'(idx[10:7]), 8'h00, 1'b1);
                doAccess(pbiBusPkg::ramWinBase + 16'(idx[6:0]), 8'h00, 1'b0);
            end
        end else begin
            doAccess(pbiBusPkg::spiDataAddr, 8'h00, 1'b0);
        end
        doAccess(pbiBusPkg::dmaAddrLo, 8'h00, 1'b0);
        doAccess(pbiBusPkg::dmaCountLo, 8'h00, 1'b0);
    endtask

    initial begin
        logic [31:0] r;
        logic [7:0]  wrongId;
        rstN          = 1'b0;
        devId         = 3'd3;
        hostReq       = '0;
        hostReqValid  = 1'b0;
        modelSel      = 1'b0;
        modelBank     = '0;
        modelDmaAddr  = '0;
        modelDmaCount = '0;
        modelBusy     = 1'b0;
        modelCs       = 1'b0;
        modelSpi      = 8'hFF;  // Receive register comes out of reset all ones
        repeat (5) @(posedge clk1);
        #1 rstN = 1'b1;
        checkPin("spiClk", spiClk, 1'b0);
        checkPin("spiCs", spiCs, 1'b0);

        randomPageAccesses();
        r       = $random(seed);
        wrongId = (r[7:0] == devOneHot) ? 8'h04 : r[7:0];
        doAccess(pbiBusPkg::selectAddr, wrongId, 1'b1);
        randomPageAccesses();
        doAccess(pbiBusPkg::selectAddr, devOneHot, 1'b1);
        fillRam();
        doAccess(pbiBusPkg::selectAddr, 8'h00, 1'b1);
        randomPageAccesses();  // Writes here must not reach the RAM
        doAccess(pbiBusPkg::selectAddr, devOneHot, 1'b1);

        windowAccesses();
        spiAccesses();
        for (int i = 0; i < 4; i++) begin
            runDma(1'b0, 1'b0);
            runDma(1'b1, 1'b0);
        end
        runDma(1'b0, 1'b1);
        runDma(1'b1, 1'b1);
        windowAccesses();

        $display("Errors: %0d hostRdata, %0d status, %0d SPI pins",
                 dataErrors, statusErrors, pinErrors);
        if (dataErrors + statusErrors + pinErrors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/pbiCard.sv
module pbiCard (
    input  logic               clk1,
    input  logic               rstN,
    input  logic [2:0]         devId,
    input  pbiBusPkg::hostReqT hostReq,
    input  logic               hostReqValid,
    output logic               hostAck,
    output logic [7:0]         hostRdata,
    input  logic               spiDi,
    output logic               spiDo,
    output logic               spiClk,
    output logic               spiCs
);

    cardPkg::localReqT            hostBusReq;
    cardPkg::localReqT            dmaBusReq;
    logic                         hostBusValid, hostBusAck;
    logic                         dmaBusValid, dmaBusAck;
    logic [7:0]                   hostBusRdata, dmaBusRdata;
    logic                         dmaBusy, dmaGo, dmaDir;
    logic [cardPkg::ramAddrW-1:0] dmaAddr, ramAddr;
    logic [15:0]                  dmaCount;
    logic                         ramSel, ramWrite, ramAck;
    logic [7:0]                   ramWdata, ramRdata;
    logic                         spiSel, spiAck;
    logic [7:0]                   spiWdata, spiRdata;

    pbiRegDecode regs (
        .clk1, .rstN, .devId, .hostReq, .hostReqValid, .hostAck, .hostRdata,
        .busReq(hostBusReq), .busReqValid(hostBusValid), .busAck(hostBusAck),
        .busRdata(hostBusRdata), .dmaBusy, .dmaAddr, .dmaCount, .dmaGo, .dmaDir, .spiCs
    );

    dmaEngine dma (
        .clk1, .rstN, .dmaGo, .dmaDir, .dmaAddr, .dmaCount, .dmaBusy,
        .busReq(dmaBusReq), .busReqValid(dmaBusValid), .busAck(dmaBusAck),
        .busRdata(dmaBusRdata)
    );

    localBusArbiter arb (
        .clk1, .rstN,
        .hostReq(hostBusReq), .hostValid(hostBusValid), .hostAck(hostBusAck),
        .hostRdata(hostBusRdata),
        .dmaReq(dmaBusReq), .dmaValid(dmaBusValid), .dmaAck(dmaBusAck),
        .dmaRdata(dmaBusRdata),
        .ramSel, .ramWrite, .ramAddr, .ramWdata, .ramAck, .ramRdata,
        .spiSel, .spiWdata, .spiAck, .spiRdata
    );

    spiShifter spi (
        .clk1, .rstN, .spiSel, .spiWdata, .spiAck, .spiRdata, .spiDi, .spiDo, .spiClk
    );

    cardRam ram (
        .clk1, .rstN, .ramSel, .ramWrite, .ramAddr, .ramWdata, .ramAck, .ramRdata
    );

endmodule

// File: verilog/pbiRegDecode.sv
module pbiRegDecode (
    input  logic                         clk1,
    input  logic                         rstN,
    input  logic [2:0]                   devId,
    input  pbiBusPkg::hostReqT           hostReq,
    input  logic                         hostReqValid,
    output logic                         hostAck,
    output logic [7:0]                   hostRdata,
    output cardPkg::localReqT            busReq,
    output logic                         busReqValid,
    input  logic                         busAck,
    input  logic [7:0]                   busRdata,
    input  logic                         dmaBusy,
    output logic [cardPkg::ramAddrW-1:0] dmaAddr,
    output logic [15:0]                  dmaCount,
    output logic                         dmaGo,
    output logic                         dmaDir,
    output logic                         spiCs
);

    typedef enum logic [1:0] {
        hpIdle,   // Waiting for a host access
        hpBus,    // Local bus request outstanding
        hpDrain,  // Local ack falling
        hpAck     // Host ack high until the host lets go
    } hostStateT;

    hostStateT   state;
    logic        selected;
    logic [3:0]  bank;
    logic [15:0] addr;
    logic        isWindow;
    logic        isBank;
    logic        dmaWrOk;

    assign addr     = hostReq.addr;
    assign isWindow = addr[15:7] == pbiBusPkg::ramWinBase[15:7];
    assign isBank   = addr[15:4] == pbiBusPkg::ramBankAddr[15:4];
    assign dmaWrOk  = hostReq.write && !dmaBusy;  // DMA regs frozen during a transfer

    always_ff @(posedge clk1) begin
        if (!rstN) begin
            state       <= hpIdle;
            hostAck     <= 1'b0;
            busReqValid <= 1'b0;
            dmaGo       <= 1'b0;
            dmaDir      <= 1'b0;
            dmaAddr     <= '0;
            dmaCount    <= '0;
            selected    <= 1'b0;
            bank        <= '0;
            spiCs       <= 1'b0;
        end else begin
            dmaGo <= 1'b0;  // Single-cycle start pulse
            case (state)
                hpIdle: if (hostReqValid) begin
                    hostRdata <= pbiBusPkg::idleData;
                    if (selected && (isWindow || addr == pbiBusPkg::spiDataAddr)) begin
                        // Window and SPI data go out over the local bus
                        busReq.target <= isWindow ? cardPkg::tgtRam : cardPkg::tgtSpi;
                        busReq.op     <= hostReq.write ? cardPkg::opWrite : cardPkg::opRead;
                        busReq.addr   <= {bank, addr[6:0]};
                        busReq.wdata  <= hostReq.wdata;
                        busReqValid   <= 1'b1;
                        state         <= hpBus;
                    end else begin
                        hostAck <= 1'b1;
                        state   <= hpAck;
                        if (addr == pbiBusPkg::selectAddr) begin
                            if (hostReq.write) begin
                                selected <= hostReq.wdata == (8'd1 << devId);
                            end
                        end else if (selected && isBank) begin
                            if (hostReq.write) bank <= addr[3:0];
                            hostRdata <= {4'h0, bank};
                        end else if (selected) begin
                            case (addr)
                                pbiBusPkg::dmaAddrLo: begin
                                    if (dmaWrOk) dmaAddr[7:0] <= hostReq.wdata;
                                    hostRdata <= dmaAddr[7:0];
                                end
                                pbiBusPkg::dmaAddrHi: begin
                                    if (dmaWrOk) dmaAddr[10:8] <= hostReq.wdata[2:0];
                                    hostRdata <= {5'h0, dmaAddr[10:8]};
                                end
                                pbiBusPkg::dmaCountLo: begin
                                    if (dmaWrOk) dmaCount[7:0] <= hostReq.wdata;
                                    hostRdata <= dmaCount[7:0];
                                end
                                pbiBusPkg::dmaCountHi: begin
                                    if (dmaWrOk) dmaCount[15:8] <= hostReq.wdata;
                                    hostRdata <= dmaCount[15:8];
                                end
                                pbiBusPkg::dmaStart: if (dmaWrOk) begin
                                    dmaGo  <= 1'b1;
                                    dmaDir <= hostReq.wdata[0];
                                end
                                pbiBusPkg::statusAddr: hostRdata <= {6'h0, spiCs, dmaBusy};
                                pbiBusPkg::spiSelAddr: begin
                                    if (hostReq.write) spiCs <= hostReq.wdata[0];
                                    hostRdata <= {7'h0, spiCs};
                                end
                                default: ;  // Unmapped, reads float
                            endcase
                        end
                    end
                end
                hpBus: if (busAck) begin
                    busReqValid <= 1'b0;
                    hostRdata   <= busRdata;
                    state       <= hpDrain;
                end
                hpDrain: if (!busAck) begin
                    hostAck <= 1'b1;
                    state   <= hpAck;
                end
                hpAck: if (!hostReqValid) begin
                    hostAck <= 1'b0;
                    state   <= hpIdle;
                end
                default: state <= hpIdle;
            endcase
        end
    end

    // The host must have been asking in the cycle the ack went up
    ackNeedsReq: assert property (@(posedge clk1) disable iff (!rstN)
        $rose(hostAck) |-> $past(hostReqValid));

endmodule

// File: verilog/dmaEngine.sv
module dmaEngine (
    input  logic                         clk1,
    input  logic                         rstN,
    input  logic                         dmaGo,
    input  logic                         dmaDir,  // 0 RAM to SPI, 1 SPI to RAM
    input  logic [cardPkg::ramAddrW-1:0] dmaAddr,
    input  logic [15:0]                  dmaCount,
    output logic                         dmaBusy,
    output cardPkg::localReqT            busReq,
    output logic                         busReqValid,
    input  logic                         busAck,
    input  logic [7:0]                   busRdata
);

    cardPkg::dmaStateT            state;
    logic [cardPkg::ramAddrW-1:0] workAddr;
    logic [15:0]                  workCount;
    logic                         dir;
    logic [7:0]                   dataHold;  // Byte carried from fetch to store
    logic                         waitDrop;  // Req dropped, ack still high

    assign dmaBusy = state != cardPkg::dmaIdle;

    // Request follows the step; it only changes once the ack has fallen
    always_comb begin
        busReq.addr = workAddr;
        if (state == cardPkg::dmaStore) begin
            busReq.target = dir ? cardPkg::tgtRam : cardPkg::tgtSpi;
            busReq.op     = cardPkg::opWrite;
            busReq.wdata  = dataHold;
        end else begin
            busReq.target = dir ? cardPkg::tgtSpi : cardPkg::tgtRam;
            busReq.op     = dir ? cardPkg::opWrite : cardPkg::opRead;
            busReq.wdata  = cardPkg::spiFill;
        end
    end

    always_ff @(posedge clk1) begin
        if (!rstN) begin
            state       <= cardPkg::dmaIdle;
            busReqValid <= 1'b0;
            waitDrop    <= 1'b0;
            workCount   <= '0;
        end else if (state == cardPkg::dmaIdle) begin
            if (dmaGo && dmaCount != 16'd0) begin  // Zero count is a no-op
                workAddr    <= dmaAddr;
                workCount   <= dmaCount;
                dir         <= dmaDir;
                state       <= cardPkg::dmaFetch;
                busReqValid <= 1'b1;
            end
        end else if (!waitDrop) begin
            if (busAck) begin
                busReqValid <= 1'b0;
                waitDrop    <= 1'b1;
                if (state == cardPkg::dmaFetch) dataHold <= busRdata;
            end
        end else if (!busAck) begin
            // Handshake closed, move to the next step
            waitDrop <= 1'b0;
            if (state == cardPkg::dmaFetch) begin
                state       <= cardPkg::dmaStore;
                busReqValid <= 1'b1;
            end else begin
                workAddr  <= workAddr + 1'b1;
                workCount <= workCount - 16'd1;
                if (workCount == 16'd1) begin
                    state <= cardPkg::dmaIdle;
                end else begin
                    state       <= cardPkg::dmaFetch;
                    busReqValid <= 1'b1;
                end
            end
        end
    end

    // Count only moves when loaded or after a store
    countFrozenIdle: assert property (@(posedge clk1) disable iff (!rstN)
        (state == cardPkg::dmaIdle && !dmaGo) |=> $stable(workCount));

endmodule

// File: verilog/localBusArbiter.sv
module localBusArbiter (
    input  logic                         clk1,
    input  logic                         rstN,
    input  cardPkg::localReqT            hostReq,
    input  logic                         hostValid,
    output logic                         hostAck,
    output logic [7:0]                   hostRdata,
    input  cardPkg::localReqT            dmaReq,
    input  logic                         dmaValid,
    output logic                         dmaAck,
    output logic [7:0]                   dmaRdata,
    output logic                         ramSel,
    output logic                         ramWrite,
    output logic [cardPkg::ramAddrW-1:0] ramAddr,
    output logic [7:0]                   ramWdata,
    input  logic                         ramAck,
    input  logic [7:0]                   ramRdata,
    output logic                         spiSel,
    output logic [7:0]                   spiWdata,
    input  logic                         spiAck,
    input  logic [7:0]                   spiRdata
);

    logic              grantHost;
    logic              grantDma;
    cardPkg::localReqT req;
    logic              active;
    logic              slaveAck;
    logic [7:0]        slaveRdata;

    assign req      = grantHost ? hostReq : dmaReq;
    assign active   = grantHost ? hostValid : (grantDma && dmaValid);
    assign slaveAck = ramAck | spiAck;  // Only one slave is ever selected

    assign ramSel   = active && req.target == cardPkg::tgtRam;
    assign spiSel   = active && req.target == cardPkg::tgtSpi;
    assign ramWrite = req.op == cardPkg::opWrite;
    assign ramAddr  = req.addr;
    assign ramWdata = req.wdata;
    // SPI read resends the last received byte
    assign spiWdata = req.op == cardPkg::opWrite ? req.wdata : spiRdata;

    assign slaveRdata = req.target == cardPkg::tgtSpi ? spiRdata : ramRdata;
    assign hostAck    = grantHost && slaveAck;
    assign dmaAck     = grantDma && slaveAck;
    assign hostRdata  = slaveRdata;
    assign dmaRdata   = slaveRdata;

    always_ff @(posedge clk1) begin
        if (!rstN) begin
            grantHost <= 1'b0;
            grantDma  <= 1'b0;
        end else if (!grantHost && !grantDma) begin
            if (hostValid) grantHost <= 1'b1;  // Host first
            else if (dmaValid) grantDma <= 1'b1;
        end else if (!active && !slaveAck) begin
            // Four-phase cycle done, free the bus
            grantHost <= 1'b0;
            grantDma  <= 1'b0;
        end
    end

    oneGrant: assert property (@(posedge clk1) disable iff (!rstN)
        !(grantHost && grantDma));

endmodule

// File: verilog/spiShifter.sv
module spiShifter (
    input  logic       clk1,
    input  logic       rstN,
    input  logic       spiSel,
    input  logic [7:0] spiWdata,
    output logic       spiAck,
    output logic [7:0] spiRdata,
    input  logic       spiDi,
    output logic       spiDo,
    output logic       spiClk
);

    logic [7:0] shiftReg;
    logic [2:0] bitCnt;
    logic       busy;
    logic       sampled;  // spiDi taken on the rising spiClk

    assign spiDo = shiftReg[7];  // MSB first

    always_ff @(posedge clk1) begin
        if (!rstN) begin
            busy     <= 1'b0;
            spiAck   <= 1'b0;
            spiClk   <= 1'b0;
            bitCnt   <= '0;
            spiRdata <= 8'hFF;
        end else if (!busy) begin
            if (spiAck && !spiSel) begin
                spiAck <= 1'b0;
            end else if (spiSel && !spiAck) begin
                shiftReg <= spiWdata;
                bitCnt   <= '0;
                busy     <= 1'b1;
            end
        end else begin
            spiClk <= !spiClk;  // Divide by two
            if (!spiClk) begin
                sampled <= spiDi;
            end else begin
                shiftReg <= {shiftReg[6:0], sampled};
                bitCnt   <= bitCnt + 1'b1;
                if (bitCnt == 3'd7) begin
                    spiRdata <= {shiftReg[6:0], sampled};
                    busy     <= 1'b0;
                    spiAck   <= 1'b1;
                end
            end
        end
    end

endmodule

// File: verilog/cardRam.sv
module cardRam (
    input  logic                         clk1,
    input  logic                         rstN,
    input  logic                         ramSel,
    input  logic                         ramWrite,
    input  logic [cardPkg::ramAddrW-1:0] ramAddr,
    input  logic [7:0]                   ramWdata,
    output logic                         ramAck,
    output logic [7:0]                   ramRdata
);

    logic [7:0] mem [cardPkg::ramBytes];

    // One access per select, data held while ack is up
    always_ff @(posedge clk1) begin
        if (ramSel && !ramAck) begin
            if (ramWrite) mem[ramAddr] <= ramWdata;
            ramRdata <= mem[ramAddr];
        end
    end

    // Ack follows select one cycle late, both ways
    always_ff @(posedge clk1) begin
        if (!rstN) begin
            ramAck <= 1'b0;
        end else begin
            ramAck <= ramSel;
        end
    end

endmodule

// File: verilog/cardPkg.sv
// Card side: local bus between the requesters and RAM/SPI, plus DMA types
package cardPkg;

    localparam int ramAddrW = 11;
    localparam int ramBytes = 2048;

    // Which local slave a request goes to
    typedef enum logic {
        tgtRam,
        tgtSpi
    } targetT;

    typedef enum logic {
        opRead,
        opWrite
    } opT;

    // Local bus request, held stable while req is high
    typedef struct packed {
        targetT              target;
        opT                  op;
        logic [ramAddrW-1:0] addr;   // Ignored by the SPI port
        logic [7:0]          wdata;
    } localReqT;

    // One fetch and one store per byte moved
    typedef enum logic [1:0] {
        dmaIdle,
        dmaFetch,
        dmaStore
    } dmaStateT;

    // Byte shifted out while DMA receives from SPI
    localparam logic [7:0] spiFill = 8'hFF;

endpackage

// File: verilog/pbiBusPkg.sv
// Host side of the card: bus request shape and the D1xx register page
package pbiBusPkg;

    // One host access as seen on the parallel bus
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        write;  // 1 = host writes
    } hostReqT;

    // Banked window, 128 bytes at D100..D17F
    localparam logic [15:0] ramWinBase  = 16'hD100;
    // D1E0..D1EF, bank number comes from the low address nibble
    localparam logic [15:0] ramBankAddr = 16'hD1E0;

    // DMA address and count, little endian pairs
    localparam logic [15:0] dmaAddrLo   = 16'hD1F7;
    localparam logic [15:0] dmaAddrHi   = 16'hD1F8;
    localparam logic [15:0] dmaCountLo  = 16'hD1F9;
    localparam logic [15:0] dmaCountHi  = 16'hD1FA;
    localparam logic [15:0] dmaStart    = 16'hD1FB;  // Data bit 0 is the direction

    localparam logic [15:0] statusAddr  = 16'hD1FC;  // Bit 0 DMA busy, bit 1 SPI select
    localparam logic [15:0] spiSelAddr  = 16'hD1FD;
    localparam logic [15:0] spiDataAddr = 16'hD1FE;

    // Card enable, written with the one-hot device ID
    localparam logic [15:0] selectAddr  = 16'hD1FF;

    // Floating bus value for unmapped or deselected reads
    localparam logic [7:0]  idleData    = 8'hFF;

endpackage
